// File: verilog.f
core_pkg.sv
amo_alu.sv
load_formatter.sv
memory_stage.sv
data_memory.sv
mem_subsystem_top.sv
mem_subsystem_asserts.sv
tb_mem_subsystem.sv

// File: tb_mem_subsystem.sv
`timescale 1ns/10ps

module tb_mem_subsystem;

    localparam int DIRECTED_OPS    = 100;  // upper bound of the directed tests
    localparam int RANDOM_OPS      = 400;
    localparam int LOAD_CYCLES     = 2 + core_pkg::MEM_LATENCY;
    localparam int AMO_CYCLES      = 3 + 2 * core_pkg::MEM_LATENCY;
    localparam int WATCHDOG_CYCLES = (DIRECTED_OPS + RANDOM_OPS) * AMO_CYCLES + 20;

    logic                clk;
    logic                reset;
    logic                valid;
    core_pkg::mem_sel_t  mem_op;
    core_pkg::mem_size_t mem_size;
    core_pkg::sign_sel_t sign_sel;
    core_pkg::aext_sel_t a_sel;
    logic [31:0]         alu_out;
    logic [31:0]         rs2_data;
    logic [31:0]         mem_rdata;
    logic                is_stall;

    // shadow state of the reference model
    logic [31:0] shadow_mem [core_pkg::MEM_WORDS] = '{default: '0};
    logic        resv_valid = 1'b0;
    logic [31:0] resv_addr = '0;

    logic [31:0] expected_rdata;
    logic [31:0] last_lr_addr = '0;
    int stall_count = 0;
    int op_count = 0;
    int check_count = 0;
    int timing_checks = 0;
    int mismatch_count = 0;
    int timing_errors = 0;
    int test_num = 0;
    int errors_before = 0;
    int ops_before = 0;

    mem_subsystem_top mem_subsystem_top_i (
        .clk       (clk),
        .reset     (reset),
        .valid     (valid),
        .mem_op    (mem_op),
        .mem_size  (mem_size),
        .sign_sel  (sign_sel),
        .a_sel     (a_sel),
        .alu_out   (alu_out),
        .rs2_data  (rs2_data),
        .mem_rdata (mem_rdata),
        .is_stall  (is_stall)
    );

    bind memory_stage mem_subsystem_asserts mem_subsystem_asserts_i (
        .clk         (clk),
        .reset       (reset),
        .is_stall    (is_stall),
        .dreq_valid  (dreq_valid),
        .dreq_ready  (dreq_ready),
        .dresp_valid (dresp_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // expected mem_rdata of one operation, advances the shadow state
    function automatic logic [31:0] model_op(
        input core_pkg::mem_sel_t  op,
        input core_pkg::mem_size_t size,
        input core_pkg::sign_sel_t sign,
        input core_pkg::aext_sel_t asel,
        input logic [31:0]         addr,
        input logic [31:0]         data
    );
        logic [31:0] old_word;
        logic [31:0] new_word;
        logic [31:0] result;
        logic [7:0]  b;
        logic [15:0] h;
        logic        lt;
        int          idx;
        idx      = int'(addr[9:2]);
        old_word = shadow_mem[idx];
        new_word = old_word;
        result   = old_word;
        lt = (sign == core_pkg::OP_SIGNED) ? ($signed(old_word) < $signed(data)) :
                                             (old_word < data);
        case (op)
            core_pkg::MEN_L: begin
                if (size == core_pkg::SIZE_B) begin
                    b      = old_word[8*addr[1:0] +: 8];
                    result = {{24{sign == core_pkg::OP_SIGNED && b[7]}}, b};
                end else if (size == core_pkg::SIZE_H) begin
                    h      = old_word[8*addr[1:0] +: 16];
                    result = {{16{sign == core_pkg::OP_SIGNED && h[15]}}, h};
                end
            end
            core_pkg::MEN_S: begin
                if (size == core_pkg::SIZE_B) begin
                    new_word[8*addr[1:0] +: 8] = data[7:0];
                end else if (size == core_pkg::SIZE_H) begin
                    new_word[8*addr[1:0] +: 16] = data[15:0];
                end else begin
                    new_word = data;
                end
            end
            core_pkg::MEN_A: begin
                case (asel)
                    core_pkg::ASEL_LR: begin
                        resv_valid = 1'b1;
                        resv_addr  = addr;
                    end
                    core_pkg::ASEL_SC: begin
                        result = (resv_valid && resv_addr == addr) ? 32'd0 : 32'd1;
                        if (result == 32'd0) begin
                            new_word = data;
                        end
                        resv_valid = 1'b0;  // any sc ends the reservation
                    end
                    core_pkg::ASEL_AMO_SWAP: new_word = data;
                    core_pkg::ASEL_AMO_ADD:  new_word = old_word + data;
                    core_pkg::ASEL_AMO_XOR:  new_word = old_word ^ data;
                    core_pkg::ASEL_AMO_AND:  new_word = old_word & data;
                    core_pkg::ASEL_AMO_OR:   new_word = old_word | data;
                    core_pkg::ASEL_AMO_MIN:  new_word = lt ? old_word : data;
                    core_pkg::ASEL_AMO_MAX:  new_word = lt ? data : old_word;
                    default: ;
                endcase
            end
            default: ;
        endcase
        shadow_mem[idx] = new_word;
        return result;
    endfunction

    // compare at every retiring memory operation
    always @(posedge clk) begin
        if (!reset && valid && !is_stall && mem_op != core_pkg::MEN_X) begin
            expected_rdata = model_op(mem_op, mem_size, sign_sel, a_sel, alu_out, rs2_data);
            if (mem_op != core_pkg::MEN_S) begin  // stores return nothing defined
                check_count++;
                if (mem_rdata !== expected_rdata) begin
                    $display("Error at %0t ns: mem_rdata expected %08h, got %08h",
                             $time, expected_rdata, mem_rdata);
                    mismatch_count++;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles, DUT hangs",
                 WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

    function automatic int total_errors();
        return mismatch_count + timing_errors +
               mem_subsystem_top_i.memory_stage_i.mem_subsystem_asserts_i.fail_count;
    endfunction

    task automatic run_op(
        input core_pkg::mem_sel_t  op,
        input core_pkg::mem_size_t size,
        input core_pkg::sign_sel_t sign,
        input core_pkg::aext_sel_t asel,
        input logic [31:0]         addr,
        input logic [31:0]         data
    );
        @(negedge clk);
        valid    = 1'b1;
        mem_op   = op;
        mem_size = size;
        sign_sel = sign;
        a_sel    = asel;
        alu_out  = addr;
        rs2_data = data;
        op_count++;
        stall_count = 0;
        @(posedge clk);
        while (is_stall) begin
            stall_count++;
            @(posedge clk);
        end
    endtask

    task automatic run_load(
        input core_pkg::mem_size_t size,
        input core_pkg::sign_sel_t sign,
        input logic [31:0]         addr
    );
        run_op(core_pkg::MEN_L, size, sign, core_pkg::ASEL_LR, addr, 32'h0);
    endtask

    task automatic run_store(input core_pkg::mem_size_t size, input logic [31:0] addr,
                             input logic [31:0] data);
        run_op(core_pkg::MEN_S, size, core_pkg::OP_UNSIGNED, core_pkg::ASEL_LR, addr, data);
    endtask

    task automatic run_atomic(
        input core_pkg::aext_sel_t asel,
        input core_pkg::sign_sel_t sign,
        input logic [31:0]         addr,
        input logic [31:0]         data
    );
        run_op(core_pkg::MEN_A, core_pkg::SIZE_W, sign, asel, addr, data);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        valid = 1'b0;
        op_count++;
        @(posedge clk);
        timing_checks++;
        if (is_stall !== 1'b0) begin
            $display("Error at %0t ns: is_stall expected 0, got %b", $time, is_stall);
            timing_errors++;
        end
    endtask

    task automatic check_stalls(input int expected);
        timing_checks++;
        if (stall_count != expected) begin
            $display("Error at %0t ns: is_stall cycles expected %0d, got %0d",
                     $time, expected, stall_count);
            timing_errors++;
        end
    endtask

    task automatic end_test(input string name);
        @(negedge clk);  // last compare of the test is done by now
        valid = 1'b0;
        test_num++;
        $display("test %0d %s: %0d ops, %0d errors", test_num, name,
                 op_count - ops_before, total_errors() - errors_before);
        errors_before = total_errors();
        ops_before    = op_count;
    endtask

    function automatic logic [31:0] random_addr(input core_pkg::mem_size_t size,
                                                input logic [31:0] base);
        case (size)
            core_pkg::SIZE_B: return base + ($urandom % 4);
            core_pkg::SIZE_H: return base + 2 * ($urandom % 2);
            default:          return base;
        endcase
    endfunction

    task automatic random_op();
        logic [31:0]         base;
        core_pkg::mem_size_t size;
        core_pkg::sign_sel_t sign;
        base = ($urandom % 16) * 4;  // 16 words so that addresses collide
        sign = ($urandom % 2) ? core_pkg::OP_SIGNED : core_pkg::OP_UNSIGNED;
        case ($urandom % 3)
            0:       size = core_pkg::SIZE_B;
            1:       size = core_pkg::SIZE_H;
            default: size = core_pkg::SIZE_W;
        endcase
        case ($urandom % 12)
            0: idle_cycle();
            1: run_op(core_pkg::MEN_X, size, sign, core_pkg::ASEL_LR, base, $urandom);
            2, 3: run_load(size, sign, random_addr(size, base));
            4, 5: run_store(size, random_addr(size, base), $urandom);
            6: begin
                run_atomic(core_pkg::ASEL_LR, sign, base, 32'h0);
                last_lr_addr = base;
            end
            7: run_atomic(core_pkg::ASEL_SC, sign, last_lr_addr, $urandom);
            8: run_atomic(core_pkg::ASEL_SC, sign, base, $urandom);
            default: begin
                run_atomic(core_pkg::aext_sel_t'(4'(2 + $urandom % 7)), sign, base, $urandom);
            end
        endcase
    endtask

    initial begin
        core_pkg::aext_sel_t asel;
        core_pkg::sign_sel_t sign;
        void'($urandom(71));
        reset    = 1'b1;
        valid    = 1'b0;
        mem_op   = core_pkg::MEN_X;
        mem_size = core_pkg::SIZE_W;
        sign_sel = core_pkg::OP_UNSIGNED;
        a_sel    = core_pkg::ASEL_LR;
        alu_out  = '0;
        rs2_data = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // lanes 01 7f 81 80 give both signs in every byte and half
        run_store(core_pkg::SIZE_W, 32'h10, 32'h8081_7f01);
        run_store(core_pkg::SIZE_B, 32'h15, 32'hffff_ffa5);
        run_store(core_pkg::SIZE_B, 32'h17, 32'h0000_007e);
        run_store(core_pkg::SIZE_H, 32'h1a, 32'h1234_c3d2);
        run_store(core_pkg::SIZE_H, 32'h18, 32'h0000_4567);
        for (int a = 'h10; a < 'h18; a++) begin
            run_load(core_pkg::SIZE_B, core_pkg::OP_SIGNED, a);
            run_load(core_pkg::SIZE_B, core_pkg::OP_UNSIGNED, a);
        end
        for (int a = 'h10; a < 'h1c; a += 2) begin
            run_load(core_pkg::SIZE_H, core_pkg::OP_SIGNED, a);
            run_load(core_pkg::SIZE_H, core_pkg::OP_UNSIGNED, a);
        end
        for (int a = 'h10; a < 'h1c; a += 4) begin
            run_load(core_pkg::SIZE_W, core_pkg::OP_UNSIGNED, a);
        end
        end_test("sized stores and loads");

        run_op(core_pkg::MEN_X, core_pkg::SIZE_W, core_pkg::OP_UNSIGNED,
               core_pkg::ASEL_LR, 32'h40, 32'h1);
        check_stalls(0);
        idle_cycle();
        run_load(core_pkg::SIZE_W, core_pkg::OP_UNSIGNED, 32'h10);
        check_stalls(LOAD_CYCLES);
        run_store(core_pkg::SIZE_W, 32'h40, 32'h5a5a_0f0f);
        check_stalls(LOAD_CYCLES);
        end_test("stall timing");

        run_atomic(core_pkg::ASEL_LR, core_pkg::OP_SIGNED, 32'h20, 32'h0);
        check_stalls(LOAD_CYCLES);
        run_atomic(core_pkg::ASEL_SC, core_pkg::OP_SIGNED, 32'h20, 32'hcafe_0001);
        check_stalls(LOAD_CYCLES);
        run_load(core_pkg::SIZE_W, core_pkg::OP_UNSIGNED, 32'h20);
        end_test("lr then sc");

        run_atomic(core_pkg::ASEL_SC, core_pkg::OP_SIGNED, 32'h24, 32'h1111_1111);
        check_stalls(1);
        run_load(core_pkg::SIZE_W, core_pkg::OP_UNSIGNED, 32'h24);
        run_atomic(core_pkg::ASEL_LR, core_pkg::OP_SIGNED, 32'h24, 32'h0);
        run_atomic(core_pkg::ASEL_SC, core_pkg::OP_SIGNED, 32'h28, 32'h2222_2222);
        check_stalls(1);
        run_load(core_pkg::SIZE_W, core_pkg::OP_UNSIGNED, 32'h28);
        run_atomic(core_pkg::ASEL_LR, core_pkg::OP_SIGNED, 32'h2c, 32'h0);
        run_atomic(core_pkg::ASEL_SC, core_pkg::OP_SIGNED, 32'h2c, 32'h3333_3333);
        run_atomic(core_pkg::ASEL_SC, core_pkg::OP_SIGNED, 32'h2c, 32'h4444_4444);
        check_stalls(1);
        run_load(core_pkg::SIZE_W, core_pkg::OP_UNSIGNED, 32'h2c);
        end_test("failing sc");

        // old word negative as signed, large as unsigned
        for (int k = 0; k < 9; k++) begin
            if (k < 5) begin
                asel = core_pkg::aext_sel_t'(4'(k + 2));
            end else if (k < 7) begin
                asel = core_pkg::ASEL_AMO_MIN;
            end else begin
                asel = core_pkg::ASEL_AMO_MAX;
            end
            sign = (k == 6 || k == 8) ? core_pkg::OP_UNSIGNED : core_pkg::OP_SIGNED;
            run_store(core_pkg::SIZE_W, 32'h30, 32'h8000_0010);
            run_atomic(asel, sign, 32'h30, 32'h0000_0020);
            check_stalls(AMO_CYCLES);
            run_load(core_pkg::SIZE_W, core_pkg::OP_UNSIGNED, 32'h30);
        end
        end_test("amo kinds");

        repeat (RANDOM_OPS) random_op();
        end_test("random mix");

        $display("ops %0d, checks %0d, errors %0d", op_count,
                 check_count + timing_checks, total_errors());
        if (total_errors() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: mem_subsystem_asserts.sv
`timescale 1ns/10ps

module mem_subsystem_asserts (
    input logic clk,
    input logic reset,
    input logic is_stall,
    input logic dreq_valid,
    input logic dreq_ready,
    input logic dresp_valid
);

    int fail_count = 0;  // failures so far

    // request held until accepted
    assert property (@(posedge clk) disable iff (reset)
                     dreq_valid && !dreq_ready |=> dreq_valid)
    else begin
        $error("dreq_valid dropped before the request was accepted");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (reset) dreq_valid |-> is_stall)
    else begin
        $error("dreq_valid high while the stage is not stalling");
        fail_count++;
    end

    // response is a single cycle pulse
    assert property (@(posedge clk) disable iff (reset) dresp_valid |=> !dresp_valid)
    else begin
        $error("dresp_valid high for two cycles in a row");
        fail_count++;
    end

endmodule

// File: mem_subsystem_top.sv
`timescale 1ns/10ps

module mem_subsystem_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      valid,
    input  core_pkg::mem_sel_t        mem_op,
    input  core_pkg::mem_size_t       mem_size,
    input  core_pkg::sign_sel_t       sign_sel,
    input  core_pkg::aext_sel_t       a_sel,
    input  logic [core_pkg::XLEN-1:0] alu_out,
    input  logic [core_pkg::XLEN-1:0] rs2_data,
    output logic [core_pkg::XLEN-1:0] mem_rdata,
    output logic                      is_stall
);

    // stage to memory handshake
    logic                      dreq_valid;
    logic                      dreq_wen;
    logic [core_pkg::XLEN-1:0] dreq_addr;
    logic [core_pkg::XLEN-1:0] dreq_wdata;
    core_pkg::mem_size_t       dreq_wmask;
    logic                      dreq_ready;
    logic                      dresp_valid;
    logic [core_pkg::XLEN-1:0] dresp_rdata;

    memory_stage memory_stage_i (
        .clk            (clk),
        .reset          (reset),
        .valid          (valid),
        .mem_op         (mem_op),
        .mem_size       (mem_size),
        .sign_sel       (sign_sel),
        .a_sel          (a_sel),
        .alu_out        (alu_out),
        .rs2_data       (rs2_data),
        .next_mem_rdata (mem_rdata),
        .is_stall       (is_stall),
        .dreq_valid     (dreq_valid),
        .dreq_wen       (dreq_wen),
        .dreq_addr      (dreq_addr),
        .dreq_wdata     (dreq_wdata),
        .dreq_wmask     (dreq_wmask),
        .dreq_ready     (dreq_ready),
        .dresp_valid    (dresp_valid),
        .dresp_rdata    (dresp_rdata)
    );

    data_memory data_memory_i (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (dreq_valid),
        .req_wen    (dreq_wen),
        .req_addr   (dreq_addr),
        .req_wdata  (dreq_wdata),
        .req_size   (dreq_wmask),
        .req_ready  (dreq_ready),
        .resp_valid (dresp_valid),
        .resp_rdata (dresp_rdata)
    );

endmodule

// File: data_memory.sv
`timescale 1ns/10ps

module data_memory (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      req_valid,
    input  logic                      req_wen,
    input  logic [core_pkg::XLEN-1:0] req_addr,
    input  logic [core_pkg::XLEN-1:0] req_wdata,
    input  core_pkg::mem_size_t       req_size,
    output logic                      req_ready,
    output logic                      resp_valid,
    output logic [core_pkg::XLEN-1:0] resp_rdata
);

    logic [core_pkg::XLEN-1:0] mem [core_pkg::MEM_WORDS] = '{default: '0};

    logic [$clog2(core_pkg::MEM_LATENCY+1)-1:0] count;  // cycles left until response
    logic [$clog2(core_pkg::MEM_WORDS)-1:0]     word_idx;
    logic [1:0]                                 byte_off;
    logic [3:0]                                 lane_mask;
    logic [core_pkg::XLEN-1:0]                  wdata_shifted;
    logic [core_pkg::XLEN-1:0]                  rdata_q;
    logic                                       accept;

    assign word_idx = req_addr[2 +: $clog2(core_pkg::MEM_WORDS)];
    assign byte_off = req_addr[1:0];

    assign req_ready  = (count == '0);
    assign resp_valid = (count == 1'b1);
    assign resp_rdata = rdata_q;
    assign accept     = req_valid && req_ready;

    // data comes in on the low bytes, move it to its lanes
    assign wdata_shifted = req_wdata << {byte_off, 3'b000};

    always_comb begin
        case (req_size)
            core_pkg::SIZE_B: lane_mask = 4'b0001 << byte_off;
            core_pkg::SIZE_H: lane_mask = 4'b0011 << byte_off;
            default:          lane_mask = 4'b1111;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (accept) begin
            count <= ($bits(count))'(core_pkg::MEM_LATENCY);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= mem[word_idx];  // old word, also for writes
            if (req_wen) begin
                for (int i = 0; i < 4; i++) begin
                    if (lane_mask[i]) begin
                        mem[word_idx][8*i +: 8] <= wdata_shifted[8*i +: 8];
                    end
                end
            end
        end
    end

endmodule

// File: memory_stage.sv
`timescale 1ns/10ps

module memory_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      valid,
    input  core_pkg::mem_sel_t        mem_op,
    input  core_pkg::mem_size_t       mem_size,
    input  core_pkg::sign_sel_t       sign_sel,
    input  core_pkg::aext_sel_t       a_sel,
    input  logic [core_pkg::XLEN-1:0] alu_out,   // effective address
    input  logic [core_pkg::XLEN-1:0] rs2_data,

    output logic [core_pkg::XLEN-1:0] next_mem_rdata,
    output logic                      is_stall,

    output logic                      dreq_valid,
    output logic                      dreq_wen,
    output logic [core_pkg::XLEN-1:0] dreq_addr,
    output logic [core_pkg::XLEN-1:0] dreq_wdata,
    output core_pkg::mem_size_t       dreq_wmask,
    input  logic                      dreq_ready,
    input  logic                      dresp_valid,
    input  logic [core_pkg::XLEN-1:0] dresp_rdata
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_READY,
        WAIT_RVALID,
        WAIT_WVALID
    } state_t;

    state_t state;

    logic done;          // memory work finished, waiting for retire
    logic amo_write;     // second pass of an amo
    logic sc_succeeded;
    logic [core_pkg::XLEN-1:0] reserved_addr;
    logic [core_pkg::XLEN-1:0] saved_rdata;
    logic [core_pkg::XLEN-1:0] amo_wdata;

    core_pkg::mem_sel_t eff_op;
    logic               is_amo;

    // amo turns into a plain store once the old word is back
    assign eff_op = amo_write ? core_pkg::MEN_S : mem_op;

    assign is_amo = (mem_op == core_pkg::MEN_A) &&
                    (a_sel != core_pkg::ASEL_LR) &&
                    (a_sel != core_pkg::ASEL_SC);

    assign dreq_valid = (state == WAIT_READY);
    assign dreq_wen   = (eff_op == core_pkg::MEN_S) ||
                        (eff_op == core_pkg::MEN_A && a_sel == core_pkg::ASEL_SC);
    assign dreq_addr  = alu_out;
    assign dreq_wdata = is_amo ? amo_wdata : rs2_data;
    assign dreq_wmask = mem_size;

    // non-memory instructions pass straight through
    assign is_stall = valid &&
                      (state != IDLE || (!done && mem_op != core_pkg::MEN_X));

    amo_alu amo_alu_i (
        .a_sel     (a_sel),
        .sign_sel  (sign_sel),
        .mem_rdata (saved_rdata),
        .rs2_data  (rs2_data),
        .amo_wdata (amo_wdata)
    );

    load_formatter load_formatter_i (
        .mem_op       (mem_op),
        .mem_size     (mem_size),
        .sign_sel     (sign_sel),
        .a_sel        (a_sel),
        .byte_offset  (alu_out[1:0]),
        .mem_rdata    (saved_rdata),
        .sc_succeeded (sc_succeeded),
        .rdata        (next_mem_rdata)
    );

    always_ff @(posedge clk) begin
        if (dresp_valid && state == WAIT_RVALID) begin
            saved_rdata <= dresp_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= IDLE;
            done          <= 1'b0;
            amo_write     <= 1'b0;
            sc_succeeded  <= 1'b0;
            reserved_addr <= core_pkg::ADDR_NONE;
        end else begin
            case (state)
                IDLE: begin
                    if (done) begin
                        done <= 1'b0;  // retires this cycle
                    end else if (valid && mem_op != core_pkg::MEN_X) begin
                        state <= WAIT_READY;
                        if (mem_op == core_pkg::MEN_A && a_sel == core_pkg::ASEL_SC) begin
                            // any sc drops the reservation
                            reserved_addr <= core_pkg::ADDR_NONE;
                            sc_succeeded  <= (reserved_addr == alu_out);
                            if (reserved_addr != alu_out) begin
                                state <= IDLE;  // fail without touching memory
                                done  <= 1'b1;
                            end
                        end else if (mem_op == core_pkg::MEN_A &&
                                     a_sel == core_pkg::ASEL_LR) begin
                            reserved_addr <= alu_out;
                        end
                    end
                end
                WAIT_READY: begin
                    if (dreq_ready) begin
                        state <= dreq_wen ? WAIT_WVALID : WAIT_RVALID;
                    end
                end
                WAIT_RVALID: begin
                    if (dresp_valid) begin
                        if (is_amo) begin
                            state     <= WAIT_READY;  // go write the combined value
                            amo_write <= 1'b1;
                        end else begin
                            state <= IDLE;
                            done  <= 1'b1;
                        end
                    end
                end
                WAIT_WVALID: begin
                    if (dresp_valid) begin
                        state     <= IDLE;
                        done      <= 1'b1;
                        amo_write <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: load_formatter.sv
`timescale 1ns/10ps

module load_formatter (
    input  core_pkg::mem_sel_t        mem_op,
    input  core_pkg::mem_size_t       mem_size,
    input  core_pkg::sign_sel_t       sign_sel,
    input  core_pkg::aext_sel_t       a_sel,
    input  logic [1:0]                byte_offset,
    input  logic [core_pkg::XLEN-1:0] mem_rdata,
    input  logic                      sc_succeeded,
    output logic [core_pkg::XLEN-1:0] rdata
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;
    logic        ext_bit;

    assign byte_lane = mem_rdata[{byte_offset, 3'b000} +: 8];
    assign half_lane = mem_rdata[{byte_offset[1], 4'b0000} +: 16];

    always_comb begin
        rdata   = mem_rdata;  // lw, lr and amo old value
        ext_bit = 1'b0;
        if (mem_op == core_pkg::MEN_A) begin
            if (a_sel == core_pkg::ASEL_SC) begin
                rdata = sc_succeeded ? '0 : core_pkg::XLEN'(1);
            end
        end else if (mem_size == core_pkg::SIZE_B) begin
            ext_bit = (sign_sel == core_pkg::OP_SIGNED) && byte_lane[7];
            rdata   = {{(core_pkg::XLEN-8){ext_bit}}, byte_lane};
        end else if (mem_size == core_pkg::SIZE_H) begin
            ext_bit = (sign_sel == core_pkg::OP_SIGNED) && half_lane[15];
            rdata   = {{(core_pkg::XLEN-16){ext_bit}}, half_lane};
        end
    end

endmodule

// File: amo_alu.sv
`timescale 1ns/10ps

module amo_alu (
    input  core_pkg::aext_sel_t       a_sel,
    input  core_pkg::sign_sel_t       sign_sel,
    input  logic [core_pkg::XLEN-1:0] mem_rdata,  // old word from memory
    input  logic [core_pkg::XLEN-1:0] rs2_data,
    output logic [core_pkg::XLEN-1:0] amo_wdata
);

    logic mem_is_less;

    // one comparator shared by min and max
    assign mem_is_less = (sign_sel == core_pkg::OP_SIGNED) ?
                         ($signed(mem_rdata) < $signed(rs2_data)) :
                         (mem_rdata < rs2_data);

    always_comb begin
        case (a_sel)
            core_pkg::ASEL_AMO_SWAP: amo_wdata = rs2_data;
            core_pkg::ASEL_AMO_ADD:  amo_wdata = mem_rdata + rs2_data;
            core_pkg::ASEL_AMO_XOR:  amo_wdata = mem_rdata ^ rs2_data;
            core_pkg::ASEL_AMO_AND:  amo_wdata = mem_rdata & rs2_data;
            core_pkg::ASEL_AMO_OR:   amo_wdata = mem_rdata | rs2_data;
            core_pkg::ASEL_AMO_MIN: begin
                amo_wdata = mem_is_less ? mem_rdata : rs2_data;
            end
            core_pkg::ASEL_AMO_MAX: begin
                amo_wdata = mem_is_less ? rs2_data : mem_rdata;
            end
            default: amo_wdata = '0;  // lr / sc never write this
        endcase
    end

endmodule

// File: core_pkg.sv
package core_pkg;

    // data and address width
    localparam int XLEN = 32;

    // memory operation from the decoder
    typedef enum logic [1:0] {
        MEN_X,  // no memory access
        MEN_L,
        MEN_S,
        MEN_A   // atomic, see aext_sel_t
    } mem_sel_t;

    // access size, also used as the write mask code
    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W
    } mem_size_t;

    typedef enum logic {
        OP_UNSIGNED,
        OP_SIGNED
    } sign_sel_t;

    // atomic kind, only meaningful with MEN_A
    typedef enum logic [3:0] {
        ASEL_LR,
        ASEL_SC,
        ASEL_AMO_SWAP,
        ASEL_AMO_ADD,
        ASEL_AMO_XOR,
        ASEL_AMO_AND,
        ASEL_AMO_OR,
        ASEL_AMO_MIN,
        ASEL_AMO_MAX
    } aext_sel_t;

    // data memory depth in words
    localparam int MEM_WORDS = 256;

    // cycles from request acceptance to the response pulse
    localparam int MEM_LATENCY = 2;

    // reservation register value when nothing is reserved
    localparam logic [XLEN-1:0] ADDR_NONE = '1;

endpackage
